// File: verilog/led_pkg.sv
// shared constants and types for the status panel LED controller
package led_pkg;

    localparam int NUM_LEDS = 4;        // led1 grn, led1 red, led2 grn, led2 red
    localparam int PWM_BITS = 12;       // 4096 counts per period
    localparam int PHASE_BITS = 10;     // 1024 profile entries
    localparam int PROFILE_STEP = 20;   // duty change between ramp entries
    localparam int FLASH_TOGGLES = 15;  // flash intervals after reset

    // per-LED start index into the breathing profile
    // index 0 is led1 green, 3 is led2 red
    localparam logic [NUM_LEDS-1:0][PHASE_BITS-1:0] START_PHASE = {
        10'd200,
        10'd0,
        10'd700,
        10'd250
    };

    // code 2'd3 is left unnamed and treated as a no-op
    typedef enum logic [1:0] {
        MODE_AUTO   = 2'd0,
        MODE_MANUAL = 2'd1,
        MODE_OFF    = 2'd2
    } led_mode_t;

    // one host command
    typedef struct packed {
        logic [1:0]          channel;  // target LED
        led_mode_t           mode;
        logic [PWM_BITS-1:0] duty;     // only meaningful in manual mode
    } led_cmd_t;

    // applied setting of one LED
    typedef struct packed {
        led_mode_t           mode;
        logic [PWM_BITS-1:0] duty;
    } led_cfg_t;

endpackage

// File: verilog/led_tick_gen.sv
`timescale 1ns/1ns

module led_tick_gen #(
    parameter int PRESCALE = 64,
    parameter int PHASE_DIV = 2
) (
    input  logic                         sysclk,
    input  logic                         reset,
    output logic                         pwm_tick,
    output logic                         period_start,
    output logic                         phase_step,
    output logic [led_pkg::PWM_BITS-1:0] pwm_count
);

    // a prescale of 1 still needs a one bit counter
    localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam int DIV_W = (PHASE_DIV > 1) ? $clog2(PHASE_DIV) : 1;

    logic [PRE_W-1:0] pre_cnt;
    logic [DIV_W-1:0] div_cnt;

    assign pwm_tick = (pre_cnt == PRE_W'(PRESCALE - 1));

    // the tick that wraps the shared count opens a new period
    assign period_start = pwm_tick && (pwm_count == '1);

    // slow strobe for the breathing phase
    assign phase_step = period_start && (div_cnt == DIV_W'(PHASE_DIV - 1));

    always_ff @(posedge sysclk) begin
        if (reset) begin
            pre_cnt   <= '0;
            pwm_count <= '0;
            div_cnt   <= '0;
        end else begin
            pre_cnt <= pwm_tick ? '0 : pre_cnt + 1'b1;

            if (pwm_tick) begin
                pwm_count <= pwm_count + 1'b1;  // wraps at 4096
            end

            if (period_start) begin
                div_cnt <= phase_step ? '0 : div_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/led_profile_rom.sv
`timescale 1ns/1ns

module led_profile_rom (
    input  logic                                                 sysclk,
    input  logic [led_pkg::NUM_LEDS-1:0][led_pkg::PHASE_BITS-1:0] phase,
    output logic [led_pkg::NUM_LEDS-1:0][led_pkg::PWM_BITS-1:0]   duty
);

    localparam int DEPTH = 1 << led_pkg::PHASE_BITS;
    localparam int STEP = led_pkg::PROFILE_STEP;

    typedef logic [led_pkg::PWM_BITS-1:0] table_t [DEPTH];

    // breathing profile: one up/down pulse, a gap, then a double pulse
    function automatic table_t build_table();
        table_t t;
        int     seg;

        for (int i = 0; i < DEPTH; i++) begin
            t[i] = '0;  // flat segments stay dark
        end

        t[0] = led_pkg::PWM_BITS'(STEP);
        for (int i = 1; i < 100; i++) begin
            t[i] = t[i-1] + led_pkg::PWM_BITS'(STEP);
        end
        for (int i = 100; i < 200; i++) begin
            t[i] = t[i-1] - led_pkg::PWM_BITS'(STEP);
        end

        // 400..799 alternates up and down every 100 entries
        for (int i = 400; i < 800; i++) begin
            seg = (i - 400) / 100;
            if (seg[0]) begin
                t[i] = t[i-1] - led_pkg::PWM_BITS'(STEP);
            end else begin
                t[i] = t[i-1] + led_pkg::PWM_BITS'(STEP);
            end
        end

        return t;
    endfunction

    localparam table_t PROFILE = build_table();

    // one registered read port per LED
    always_ff @(posedge sysclk) begin
        for (int i = 0; i < led_pkg::NUM_LEDS; i++) begin
            duty[i] <= PROFILE[phase[i]];
        end
    end

endmodule

// File: verilog/led_cmd_decode.sv
`timescale 1ns/1ns

module led_cmd_decode #(
    parameter int CMD_DEPTH = 4
) (
    input  logic                                        sysclk,
    input  logic                                        reset,
    input  logic                                        cmd_valid,
    input  led_pkg::led_cmd_t                           cmd,
    output logic                                        credit_return,
    output led_pkg::led_cfg_t [led_pkg::NUM_LEDS-1:0]   cfg
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    led_pkg::led_cmd_t fifo_mem [CMD_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fifo_count;
    logic              push;
    logic              pop;
    led_pkg::led_cmd_t head;

    // a write into a full fifo is dropped, the host broke the credit rule
    assign push = cmd_valid && (fifo_count != CNT_W'(CMD_DEPTH));
    assign pop  = (fifo_count != '0);  // drain one per cycle
    assign head = fifo_mem[rd_ptr];

    always_ff @(posedge sysclk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fifo_count <= fifo_count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // apply the head entry, then hand the credit back a cycle later
    always_ff @(posedge sysclk) begin
        if (reset) begin
            credit_return <= 1'b0;
            for (int i = 0; i < led_pkg::NUM_LEDS; i++) begin
                cfg[i] <= '{mode: led_pkg::MODE_AUTO, duty: '0};
            end
        end else begin
            credit_return <= pop;  // no-op commands still return a credit
            if (pop && (head.mode inside {led_pkg::MODE_AUTO, led_pkg::MODE_MANUAL,
                                          led_pkg::MODE_OFF})) begin
                cfg[head.channel].mode <= head.mode;
                cfg[head.channel].duty <= head.duty;
            end
        end
    end

endmodule

// File: verilog/led_pwm_channel.sv
`timescale 1ns/1ns

module led_pwm_channel #(
    parameter logic [led_pkg::PHASE_BITS-1:0] START_PHASE = '0
) (
    input  logic                           sysclk,
    input  logic                           reset,
    input  logic                           period_start,
    input  logic                           phase_step,
    input  logic [led_pkg::PWM_BITS-1:0]   pwm_count,
    input  led_pkg::led_cfg_t              cfg,
    input  logic [led_pkg::PWM_BITS-1:0]   table_duty,
    output logic [led_pkg::PHASE_BITS-1:0] phase,
    output logic                           pwm_out
);

    logic [led_pkg::PWM_BITS-1:0] duty_q;     // duty of the running period
    logic [led_pkg::PWM_BITS-1:0] next_duty;

    always_comb begin
        case (cfg.mode)
            led_pkg::MODE_AUTO:   next_duty = table_duty;  // breathing profile
            led_pkg::MODE_MANUAL: next_duty = cfg.duty;
            default:              next_duty = '0;          // off
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            phase <= START_PHASE;
        end else if (phase_step) begin
            phase <= phase + 1'b1;  // wraps at 1024
        end
    end

    // the table read settled long before the next period boundary
    always_ff @(posedge sysclk) begin
        if (reset) begin
            duty_q <= '0;
        end else if (period_start) begin
            duty_q <= next_duty;
        end
    end

    // registered compare, one cycle behind the count
    always_ff @(posedge sysclk) begin
        if (reset) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= (pwm_count < duty_q);
        end
    end

endmodule

// File: verilog/led_output_select.sv
`timescale 1ns/1ns

module led_output_select (
    input  logic                         sysclk,
    input  logic                         reset,
    input  logic                         period_start,
    input  logic [led_pkg::NUM_LEDS-1:0] pwm_out,
    output logic                         led1_grn,
    output logic                         led1_red,
    output logic                         led2_grn,
    output logic                         led2_red
);

    localparam int FLASH_W = $clog2(led_pkg::FLASH_TOGGLES + 1);

    logic [FLASH_W-1:0] flash_cnt;
    logic               flash_mode;  // startup flash running
    logic               flash_tgl;   // red state during the flash

    // flash_mode starts set, reds stay low until the first period
    always_ff @(posedge sysclk) begin
        if (reset) begin
            flash_cnt  <= '0;
            flash_mode <= 1'b1;
            flash_tgl  <= 1'b0;
        end else if (period_start) begin
            if (flash_cnt < FLASH_W'(led_pkg::FLASH_TOGGLES)) begin
                flash_cnt <= flash_cnt + 1'b1;
                flash_tgl <= ~flash_tgl;
            end else begin
                flash_mode <= 1'b0;  // hand the pins to the channels
            end
        end
    end

    // greens dark and reds blinking together while flashing
    assign led1_grn = flash_mode ? 1'b0      : pwm_out[0];
    assign led1_red = flash_mode ? flash_tgl : pwm_out[1];
    assign led2_grn = flash_mode ? 1'b0      : pwm_out[2];
    assign led2_red = flash_mode ? flash_tgl : pwm_out[3];

endmodule

// File: verilog/led_ctrl.sv
`timescale 1ns/1ns

module led_ctrl #(
    parameter int PRESCALE = 64,
    parameter int PHASE_DIV = 2,
    parameter int CMD_DEPTH = 4
) (
    input  logic              sysclk,
    input  logic              reset,
    input  logic              cmd_valid,
    input  led_pkg::led_cmd_t cmd,
    output logic              credit_return,
    output logic              led1_grn,
    output logic              led1_red,
    output logic              led2_grn,
    output logic              led2_red
);

    logic                                                  period_start;
    logic                                                  phase_step;
    logic [led_pkg::PWM_BITS-1:0]                          pwm_count;
    led_pkg::led_cfg_t [led_pkg::NUM_LEDS-1:0]             cfg;
    logic [led_pkg::NUM_LEDS-1:0][led_pkg::PHASE_BITS-1:0] phase;
    logic [led_pkg::NUM_LEDS-1:0][led_pkg::PWM_BITS-1:0]   table_duty;
    logic [led_pkg::NUM_LEDS-1:0]                          pwm_out;

    // the raw count tick is only needed inside the generator
    led_tick_gen #(
        .PRESCALE  (PRESCALE),
        .PHASE_DIV (PHASE_DIV)
    ) tick_gen_inst (
        .sysclk       (sysclk),
        .reset        (reset),
        .pwm_tick     (),
        .period_start (period_start),
        .phase_step   (phase_step),
        .pwm_count    (pwm_count)
    );

    led_cmd_decode #(
        .CMD_DEPTH (CMD_DEPTH)
    ) cmd_decode_inst (
        .sysclk        (sysclk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .credit_return (credit_return),
        .cfg           (cfg)
    );

    led_profile_rom profile_rom_inst (
        .sysclk (sysclk),
        .phase  (phase),
        .duty   (table_duty)
    );

    // one channel per LED, each from its own start phase
    for (genvar i = 0; i < led_pkg::NUM_LEDS; i++) begin : g_chan
        led_pwm_channel #(
            .START_PHASE (led_pkg::START_PHASE[i])
        ) pwm_channel_inst (
            .sysclk       (sysclk),
            .reset        (reset),
            .period_start (period_start),
            .phase_step   (phase_step),
            .pwm_count    (pwm_count),
            .cfg          (cfg[i]),
            .table_duty   (table_duty[i]),
            .phase        (phase[i]),
            .pwm_out      (pwm_out[i])
        );
    end

    led_output_select output_select_inst (
        .sysclk       (sysclk),
        .reset        (reset),
        .period_start (period_start),
        .pwm_out      (pwm_out),
        .led1_grn     (led1_grn),
        .led1_red     (led1_red),
        .led2_grn     (led2_grn),
        .led2_red     (led2_red)
    );

endmodule

// File: testbench/led_ctrl_chk.sv
`timescale 1ns/1ns

module led_ctrl_chk #(
    parameter int CMD_DEPTH = 4
) (
    input logic                               sysclk,
    input logic                               reset,
    input logic                               cmd_valid,
    input logic                               credit_return,
    input logic [$clog2(CMD_DEPTH + 1)-1:0]   fifo_count
);

    localparam int OWE_W = $clog2(CMD_DEPTH + 1) + 1;

    logic [OWE_W-1:0] owed;  // accepted commands not yet credited

    always_ff @(posedge sysclk) begin
        if (reset) begin
            owed <= '0;
        end else begin
            owed <= owed + OWE_W'(cmd_valid) - OWE_W'(credit_return);
        end
    end

    // occupancy bounded by the credit pool
    a_count_bound: assert property (@(posedge sysclk) disable iff (reset)
        fifo_count <= CMD_DEPTH)
        else $error("command fifo count above its depth");

    // host writes only with a credit in hand
    a_no_overflow: assert property (@(posedge sysclk) disable iff (reset)
        cmd_valid |-> (fifo_count != CMD_DEPTH))
        else $error("command written into a full fifo");

    // each credit pays back a command the host already sent
    a_credit_owed: assert property (@(posedge sysclk) disable iff (reset)
        credit_return |-> (owed != '0))
        else $error("credit returned with no command outstanding");

    a_credit_low_after_reset: assert property (@(posedge sysclk)
        $past(reset) |-> !credit_return)
        else $error("credit_return high right after reset");

endmodule

bind led_cmd_decode led_ctrl_chk #(
    .CMD_DEPTH (CMD_DEPTH)
) chk_inst (
    .sysclk        (sysclk),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .credit_return (credit_return),
    .fifo_count    (fifo_count)
);

// File: testbench/led_ctrl_tb.sv
`timescale 1ns/1ns

module led_ctrl_tb;

    localparam int CMD_DEPTH = 4;
    localparam int PERIOD = 1 << led_pkg::PWM_BITS;  // sysclk cycles per pwm period
    localparam int START_TIMEOUT = 2 * PERIOD;
    localparam int PEAK = 100 * led_pkg::PROFILE_STEP;  // top of the breathing ramps

    logic                         sysclk;
    logic                         reset;
    logic                         cmd_valid;
    led_pkg::led_cmd_t            cmd;
    logic                         credit_return;
    logic                         led1_grn;
    logic                         led1_red;
    logic                         led2_grn;
    logic                         led2_red;
    logic [led_pkg::NUM_LEDS-1:0] pins;

    led_pkg::led_cmd_t vec_cmd[$];
    int                vec_exp[$];
    int                hi_cnt[led_pkg::NUM_LEDS];
    int                red_diff;   // cycles where the two reds disagree
    int                credits;    // host side credit pool
    int                next_vec;
    logic [1:0]        pend_mode[led_pkg::NUM_LEDS];
    int                pend_exp[led_pkg::NUM_LEDS];
    logic [1:0]        act_mode[led_pkg::NUM_LEDS];
    int                act_exp[led_pkg::NUM_LEDS];
    int                prev_cnt[led_pkg::NUM_LEDS];
    logic              prev_auto[led_pkg::NUM_LEDS];
    int                errors;
    int                timeouts;
    int unsigned       seed;

    assign pins = {led2_red, led2_grn, led1_red, led1_grn};

    led_ctrl #(
        .PRESCALE  (1),
        .PHASE_DIV (1),
        .CMD_DEPTH (CMD_DEPTH)
    ) led_ctrl_inst (
        .sysclk        (sysclk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .credit_return (credit_return),
        .led1_grn      (led1_grn),
        .led1_red      (led1_red),
        .led2_grn      (led2_grn),
        .led2_red      (led2_red)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    function automatic string pin_name(input int idx);
        case (idx)
            0:       return "led1_grn";
            1:       return "led1_red";
            2:       return "led2_grn";
            default: return "led2_red";
        endcase
    endfunction

    task automatic load_vectors();
        int                fd;
        string             line;
        int                ch;
        int                md;
        int                du;
        int                ex;
        led_pkg::led_cmd_t c;

        fd = $fopen("testbench/led_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/led_vectors.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#" &&
                $sscanf(line, "%h %h %h %h", ch, md, du, ex) == 4) begin
                c.channel = ch[1:0];
                c.mode    = led_pkg::led_mode_t'(md[1:0]);
                c.duty    = du[led_pkg::PWM_BITS-1:0];
                vec_cmd.push_back(c);
                vec_exp.push_back(ex);
            end
        end
        $fclose(fd);
    endtask

    // one pwm period of samples, issuing vectors below last_vec from cycle gap on
    task automatic run_window(input int last_vec, input int gap);
        hi_cnt   = '{default: 0};
        red_diff = 0;
        for (int cyc = 0; cyc < PERIOD; cyc++) begin
            for (int i = 0; i < led_pkg::NUM_LEDS; i++) begin
                hi_cnt[i] += int'(pins[i]);
            end
            red_diff += int'(led1_red != led2_red);
            credits  += int'(credit_return);
            cmd_valid = 1'b0;
            if (cyc >= gap && next_vec < last_vec && next_vec < vec_cmd.size() &&
                credits > 0) begin
                cmd       = vec_cmd[next_vec];
                cmd_valid = 1'b1;
                credits--;
                if (cmd.mode != 2'd3) begin  // unused code leaves the config alone
                    pend_mode[cmd.channel] = cmd.mode;
                    pend_exp[cmd.channel]  = vec_exp[next_vec];
                end
                next_vec++;
            end
            @(negedge sysclk);
        end
    endtask

    task automatic check_flash();
        int exp_hi;

        for (int k = 0; k < led_pkg::FLASH_TOGGLES; k++) begin
            run_window(0, 0);
            for (int i = 0; i < led_pkg::NUM_LEDS; i++) begin
                exp_hi = (i % 2 == 1 && k % 2 == 0) ? PERIOD : 0;  // reds lit in even periods
                if (hi_cnt[i] != exp_hi) begin
                    $display("[FAIL] %s flash period %0d: got 0x%0h, expected 0x%0h",
                             pin_name(i), k, hi_cnt[i], exp_hi);
                    errors++;
                end
            end
            if (red_diff != 0) begin
                $display("led1_red and led2_red differ in %0d cycles of flash period %0d",
                         red_diff, k);
                errors++;
            end
        end
    endtask

    task automatic score_period();
        int diff;

        for (int i = 0; i < led_pkg::NUM_LEDS; i++) begin
            diff = hi_cnt[i] - prev_cnt[i];
            if (act_mode[i] == led_pkg::MODE_AUTO) begin
                if (hi_cnt[i] % led_pkg::PROFILE_STEP != 0 || hi_cnt[i] > PEAK) begin
                    $display("[FAIL] %s auto high count: got 0x%0h, expected a step up to 0x%0h",
                             pin_name(i), hi_cnt[i], PEAK);
                    errors++;
                end else if (prev_auto[i] && diff != 0 && diff != led_pkg::PROFILE_STEP &&
                             diff != -led_pkg::PROFILE_STEP) begin
                    $display("[FAIL] %s auto step: got 0x%0h after 0x%0h",
                             pin_name(i), hi_cnt[i], prev_cnt[i]);
                    errors++;
                end
            end else if (hi_cnt[i] != act_exp[i]) begin
                $display("[FAIL] %s high count: got 0x%0h, expected 0x%0h",
                         pin_name(i), hi_cnt[i], act_exp[i]);
                errors++;
            end
            prev_cnt[i]  = hi_cnt[i];
            prev_auto[i] = (act_mode[i] == led_pkg::MODE_AUTO);
        end
        if (credits != CMD_DEPTH) begin
            $display("[FAIL] credit_return total: got 0x%0h, expected 0x%0h", credits, CMD_DEPTH);
            errors++;
            credits = CMD_DEPTH;
        end
    endtask

    initial begin
        int wait_cnt;

        errors    = 0;
        timeouts  = 0;
        seed      = $urandom(32'h9def);
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        credits   = CMD_DEPTH;
        next_vec  = 0;
        for (int i = 0; i < led_pkg::NUM_LEDS; i++) begin
            pend_mode[i] = led_pkg::MODE_AUTO;
            pend_exp[i]  = 0;
            prev_cnt[i]  = 0;
            prev_auto[i] = 1'b0;
        end
        load_vectors();
        repeat (4) @(posedge sysclk);  // four clock edges in reset
        @(negedge sysclk);
        reset = 1'b0;

        // everything dark until the first period starts the flash
        wait_cnt = 0;
        while (!led1_red && wait_cnt < START_TIMEOUT) begin
            if (led1_grn || led2_grn || led2_red) begin
                $display("[FAIL] pins before first period: got 0x%0h, expected 0x0", pins);
                errors++;
            end
            @(negedge sysclk);
            wait_cnt++;
        end

        if (!led1_red) begin
            $display("timeout while waiting for led1_red to start the startup flash");
            timeouts++;
        end else begin
            check_flash();
            @(negedge sysclk);  // pins still show the tail of the old period here
            for (int w = 0; w < vec_cmd.size() - 1; w++) begin
                act_mode = pend_mode;
                act_exp  = pend_exp;
                if (w == 0) begin
                    run_window(4, 0);  // four commands back to back
                end else begin
                    run_window(next_vec + 1, $urandom % 300);
                end
                score_period();
            end
        end

        $display("errors: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: testbench/led_vectors.txt
# one host command per line, fields in hex: channel mode duty expected_high_count
# mode 0 auto, 1 manual, 2 off, 3 unused code that keeps the earlier setting
# expected count applies to manual and off, auto pins follow the breathing profile
0 1 000 0000
1 1 fff 0fff
2 1 800 0800
3 2 000 0000
0 1 001 0001
1 1 7d0 07d0
3 1 abc 0abc
2 0 000 0000
1 3 123 07d0
0 2 000 0000
2 1 014 0014
3 0 000 0000
1 1 fff 0fff
0 1 ffe 0ffe
2 2 000 0000
3 1 001 0001
1 0 000 0000
0 0 000 0000
2 1 555 0555
3 2 000 0000

// File: files.f
verilog/led_pkg.sv
verilog/led_tick_gen.sv
verilog/led_profile_rom.sv
verilog/led_cmd_decode.sv
verilog/led_pwm_channel.sv
verilog/led_output_select.sv
verilog/led_ctrl.sv
testbench/led_ctrl_chk.sv
testbench/led_ctrl_tb.sv

// File: Bender.yml
package:
  name: led_ctrl

sources:
  - files:
      - verilog/led_pkg.sv
      - verilog/led_tick_gen.sv
      - verilog/led_profile_rom.sv
      - verilog/led_cmd_decode.sv
      - verilog/led_pwm_channel.sv
      - verilog/led_output_select.sv
      - verilog/led_ctrl.sv
  - target: test
    files:
      - testbench/led_ctrl_chk.sv
      - testbench/led_ctrl_tb.sv
